//--- logic/eth_frame_loop_pkg.sv
package eth_frame_loop_pkg;

	// One frame byte
	typedef logic [7:0] byte_t;

	// Script entry for one byte position of a script
	typedef logic [31:0] script_word_t;

	localparam int CMP_MASK_LSB = 24;
	localparam int CMP_VALUE_LSB = 16;
	localparam int EDIT_MASK_LSB = 8;
	localparam int EDIT_VALUE_LSB = 0;

	// Dropped frame counter
	typedef logic [31:0] count_t;

	// Result stage FSM
	typedef enum logic [1:0] {
		idle,
		fetch,
		stream
	} tx_state_t;

endpackage

//--- logic/eth_frame_loop_if.sv
`timescale 1ns/1ps

interface eth_frame_loop_if #(
	parameter int C_NUM_SCRIPTS = 4,
	parameter int C_MAX_SCRIPT_SIZE = 16
);
	localparam int C_OFF_W = $clog2(C_MAX_SCRIPT_SIZE + 1);
	localparam int C_SCRIPT_W = C_NUM_SCRIPTS > 1 ? $clog2(C_NUM_SCRIPTS) : 1;

	eth_frame_loop_pkg::byte_t tdata;
	logic tuser;
	logic tlast;
	logic tvalid;
	// Saturates at the script size
	logic [C_OFF_W-1:0] offset;
	// Valid on the last beat only
	logic hit;
	logic [C_SCRIPT_W-1:0] hit_script;

	modport src(output tdata, tuser, tlast, tvalid, offset, hit, hit_script);

	modport dst(input tdata, tuser, tlast, tvalid, offset, hit, hit_script);

endinterface

//--- logic/eth_frame_loop_script_ram.sv
`timescale 1ns/1ps

module eth_frame_loop_script_ram #(
	parameter int C_NUM_SCRIPTS = 4,
	parameter int C_MAX_SCRIPT_SIZE = 16,
	localparam int C_ADDR_W = $clog2(C_NUM_SCRIPTS * C_MAX_SCRIPT_SIZE),
	localparam int C_IDX_W = C_MAX_SCRIPT_SIZE > 1 ? $clog2(C_MAX_SCRIPT_SIZE) : 1
) (
	input logic clk,
	input logic arst_n,

	input logic mem_req,
	input logic [C_ADDR_W-1:0] mem_addr,
	input logic mem_wenable,
	input eth_frame_loop_pkg::script_word_t mem_wdata,
	output eth_frame_loop_pkg::script_word_t mem_rdata,
	output logic mem_ack,

	input logic [C_IDX_W-1:0] rd_a_addr,
	output eth_frame_loop_pkg::script_word_t [C_NUM_SCRIPTS-1:0] rd_a_data,

	input logic [C_ADDR_W-1:0] rd_b_addr,
	output eth_frame_loop_pkg::script_word_t rd_b_data
);
	localparam int C_DEPTH = C_NUM_SCRIPTS * C_MAX_SCRIPT_SIZE;

	eth_frame_loop_pkg::script_word_t mem [C_DEPTH];

	// Cleared array matches every frame and edits nothing
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < C_DEPTH; i++) begin
				mem[i] <= '0;
			end
			mem_ack <= 1'b0;
		end else begin
			mem_ack <= mem_req;
			if (mem_req && mem_wenable) begin
				mem[mem_addr] <= mem_wdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mem_req) begin
			mem_rdata <= mem[mem_addr];
		end
		// Same offset of every script
		for (int s = 0; s < C_NUM_SCRIPTS; s++) begin
			rd_a_data[s] <= mem[s * C_MAX_SCRIPT_SIZE + int'(rd_a_addr)];
		end
		rd_b_data <= mem[rd_b_addr];
	end

endmodule

//--- logic/eth_frame_loop_rx.sv
`timescale 1ns/1ps

module eth_frame_loop_rx #(
	parameter int C_MAX_SCRIPT_SIZE = 16,
	localparam int C_OFF_W = $clog2(C_MAX_SCRIPT_SIZE + 1),
	localparam int C_IDX_W = C_MAX_SCRIPT_SIZE > 1 ? $clog2(C_MAX_SCRIPT_SIZE) : 1
) (
	input logic clk,
	input logic arst_n,

	input eth_frame_loop_pkg::byte_t s_axis_tdata,
	input logic s_axis_tuser,
	input logic s_axis_tlast,
	input logic s_axis_tvalid,

	output logic [C_IDX_W-1:0] rd_a_addr,

	eth_frame_loop_if.src cmp
);
	logic [C_OFF_W-1:0] offset;

	// Word arrives together with the registered beat
	// Beyond the script end the word is never checked
	assign rd_a_addr = (offset < C_OFF_W'(C_MAX_SCRIPT_SIZE)) ? C_IDX_W'(offset) : '0;

	// Match result comes from the compare stage
	assign cmp.hit = 1'b0;
	assign cmp.hit_script = '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			offset <= '0;
			cmp.tvalid <= 1'b0;
		end else begin
			cmp.tvalid <= s_axis_tvalid;
			if (s_axis_tvalid) begin
				if (s_axis_tlast) begin
					offset <= '0;
				end else if (offset != C_OFF_W'(C_MAX_SCRIPT_SIZE)) begin
					offset <= offset + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		cmp.tdata <= s_axis_tdata;
		cmp.tuser <= s_axis_tuser;
		cmp.tlast <= s_axis_tlast;
		cmp.offset <= offset;
	end

endmodule

//--- logic/eth_frame_loop_compare.sv
`timescale 1ns/1ps

module eth_frame_loop_compare #(
	parameter int C_NUM_SCRIPTS = 4,
	parameter int C_MAX_SCRIPT_SIZE = 16,
	localparam int C_SCRIPT_W = C_NUM_SCRIPTS > 1 ? $clog2(C_NUM_SCRIPTS) : 1
) (
	input logic clk,
	input logic arst_n,

	input logic [C_NUM_SCRIPTS-1:0] script_en,
	input eth_frame_loop_pkg::script_word_t [C_NUM_SCRIPTS-1:0] rd_a_data,

	eth_frame_loop_if.dst s,
	eth_frame_loop_if.src m
);
	logic [C_NUM_SCRIPTS-1:0] match;
	logic [C_NUM_SCRIPTS-1:0] match_next;
	logic in_script;
	logic sel_hit;
	logic [C_SCRIPT_W-1:0] sel_script;

	assign in_script = s.offset < C_MAX_SCRIPT_SIZE;

	// Any masked difference clears the script's flag for this frame
	always_comb begin
		match_next = match;
		if (in_script) begin
			for (int i = 0; i < C_NUM_SCRIPTS; i++) begin
				if (((s.tdata ^ rd_a_data[i][eth_frame_loop_pkg::CMP_VALUE_LSB +: 8])
						& rd_a_data[i][eth_frame_loop_pkg::CMP_MASK_LSB +: 8]) != 8'h00) begin
					match_next[i] = 1'b0;
				end
			end
		end
	end

	// Lowest enabled match wins
	always_comb begin
		sel_hit = 1'b0;
		sel_script = '0;
		for (int i = C_NUM_SCRIPTS - 1; i >= 0; i--) begin
			if (match_next[i] && script_en[i]) begin
				sel_hit = 1'b1;
				sel_script = C_SCRIPT_W'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			match <= {C_NUM_SCRIPTS{1'b1}};
			m.tvalid <= 1'b0;
		end else begin
			m.tvalid <= s.tvalid;
			if (s.tvalid) begin
				// Rearm all scripts for the next frame
				match <= s.tlast ? {C_NUM_SCRIPTS{1'b1}} : match_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		m.tdata <= s.tdata;
		m.tuser <= s.tuser;
		m.tlast <= s.tlast;
		m.offset <= s.offset;
		m.hit <= s.tlast && sel_hit;
		m.hit_script <= sel_script;
	end

endmodule

//--- logic/eth_frame_loop_fifo.sv
`timescale 1ns/1ps

module eth_frame_loop_fifo #(
	parameter int C_NUM_SCRIPTS = 4,
	parameter int C_LOOP_FIFO_SIZE = 64,
	localparam int C_SCRIPT_W = C_NUM_SCRIPTS > 1 ? $clog2(C_NUM_SCRIPTS) : 1,
	localparam int C_PTR_W = $clog2(C_LOOP_FIFO_SIZE),
	localparam int C_LEN_W = C_PTR_W + 1
) (
	input logic clk,
	input logic arst_n,

	eth_frame_loop_if.dst s,

	output logic ctl_valid,
	output logic [C_LEN_W-1:0] ctl_len,
	output logic ctl_hit,
	output logic [C_SCRIPT_W-1:0] ctl_script,
	input logic ctl_pop,

	input logic [C_PTR_W-1:0] rd_addr,
	output eth_frame_loop_pkg::byte_t rd_data,

	output eth_frame_loop_pkg::count_t overflow_count
);
	localparam int C_CTL_DEPTH = 4;

	eth_frame_loop_pkg::byte_t mem [C_LOOP_FIFO_SIZE];

	// Pointers with one wrap bit
	logic [C_PTR_W:0] wr_ptr, commit_ptr, rd_base;
	logic [C_PTR_W:0] used, frame_len;
	logic frame_ovf, full, drop, push;

	logic [C_LEN_W-1:0] q_len [C_CTL_DEPTH];
	logic q_hit [C_CTL_DEPTH];
	logic [C_SCRIPT_W-1:0] q_script [C_CTL_DEPTH];
	logic [1:0] q_wr, q_rd;
	logic [2:0] q_cnt;

	assign used = wr_ptr - rd_base;
	assign full = used[C_PTR_W];
	assign frame_len = wr_ptr + 1'b1 - commit_ptr;
	// Bad frame, no room for a byte, or no control slot left
	assign drop = s.tuser || frame_ovf || full || q_cnt == 3'(C_CTL_DEPTH);
	assign push = s.tvalid && s.tlast && !drop;

	assign ctl_valid = q_cnt != 3'd0;
	assign ctl_len = q_len[q_rd];
	assign ctl_hit = q_hit[q_rd];
	assign ctl_script = q_script[q_rd];

	always_ff @(posedge clk) begin
		if (s.tvalid && !full && !frame_ovf) begin
			mem[wr_ptr[C_PTR_W-1:0]] <= s.tdata;
		end
		rd_data <= mem[rd_addr];
		if (push) begin
			q_len[q_wr] <= frame_len;
			q_hit[q_wr] <= s.hit;
			q_script[q_wr] <= s.hit_script;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			commit_ptr <= '0;
			rd_base <= '0;
			frame_ovf <= 1'b0;
			q_wr <= '0;
			q_rd <= '0;
			q_cnt <= '0;
			overflow_count <= '0;
		end else begin
			if (s.tvalid) begin
				if (s.tlast) begin
					frame_ovf <= 1'b0;
					if (drop) begin
						// Rewind to the last committed frame
						wr_ptr <= commit_ptr;
						overflow_count <= overflow_count + 1'b1;
					end else begin
						wr_ptr <= wr_ptr + 1'b1;
						commit_ptr <= wr_ptr + 1'b1;
					end
				end else if (full || frame_ovf) begin
					frame_ovf <= 1'b1;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (push) begin
				q_wr <= q_wr + 1'b1;
			end
			// Space returns once the reader has issued its last fetch
			if (ctl_pop) begin
				q_rd <= q_rd + 1'b1;
				rd_base <= rd_base + ctl_len;
			end
			q_cnt <= q_cnt + 3'(push) - 3'(ctl_pop);
		end
	end

endmodule

//--- logic/eth_frame_loop_tx.sv
`timescale 1ns/1ps

module eth_frame_loop_tx #(
	parameter int C_NUM_SCRIPTS = 4,
	parameter int C_MAX_SCRIPT_SIZE = 16,
	parameter int C_LOOP_FIFO_SIZE = 64,
	localparam int C_SCRIPT_W = C_NUM_SCRIPTS > 1 ? $clog2(C_NUM_SCRIPTS) : 1,
	localparam int C_PTR_W = $clog2(C_LOOP_FIFO_SIZE),
	localparam int C_LEN_W = C_PTR_W + 1,
	localparam int C_ADDR_W = $clog2(C_NUM_SCRIPTS * C_MAX_SCRIPT_SIZE),
	localparam int C_OFF_W = $clog2(C_MAX_SCRIPT_SIZE + 1)
) (
	input logic clk,
	input logic arst_n,

	input logic ctl_valid,
	input logic [C_LEN_W-1:0] ctl_len,
	input logic ctl_hit,
	input logic [C_SCRIPT_W-1:0] ctl_script,
	output logic ctl_pop,

	output logic [C_PTR_W-1:0] rd_addr,
	input eth_frame_loop_pkg::byte_t rd_data,
	output logic [C_ADDR_W-1:0] rd_b_addr,
	input eth_frame_loop_pkg::script_word_t rd_b_data,

	output eth_frame_loop_pkg::byte_t m_axis_tdata,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	input logic m_axis_tready
);
	eth_frame_loop_pkg::tx_state_t state;
	logic [C_LEN_W-1:0] remaining;
	logic [C_OFF_W-1:0] off;
	logic hit_q;
	logic [C_SCRIPT_W-1:0] script_q;
	logic issue, edit_ok, pop;
	logic land, land_edit, land_last;
	eth_frame_loop_pkg::byte_t edit_mask, edit_value, land_byte;
	eth_frame_loop_pkg::byte_t buf_data [2];
	logic buf_last [2];
	logic buf_wr, buf_rd;
	logic [1:0] buf_cnt;

	assign edit_ok = hit_q && off < C_OFF_W'(C_MAX_SCRIPT_SIZE);
	assign pop = m_axis_tvalid && m_axis_tready;
	// Fetch only if a slot is free when the data lands
	assign issue = state == eth_frame_loop_pkg::fetch
		&& (int'(buf_cnt) + int'(land) - int'(pop)) < 2;
	assign ctl_pop = issue && remaining == C_LEN_W'(1);
	assign rd_b_addr = C_ADDR_W'(int'(script_q) * C_MAX_SCRIPT_SIZE
		+ (edit_ok ? int'(off) : 0));

	assign edit_mask = rd_b_data[eth_frame_loop_pkg::EDIT_MASK_LSB +: 8];
	assign edit_value = rd_b_data[eth_frame_loop_pkg::EDIT_VALUE_LSB +: 8];
	assign land_byte = land_edit ? ((rd_data & ~edit_mask) | (edit_value & edit_mask)) : rd_data;

	assign m_axis_tvalid = buf_cnt != 2'd0;
	assign m_axis_tdata = buf_data[buf_rd];
	assign m_axis_tlast = buf_last[buf_rd];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= eth_frame_loop_pkg::idle;
			rd_addr <= '0;
			land <= 1'b0;
			buf_wr <= 1'b0;
			buf_rd <= 1'b0;
			buf_cnt <= '0;
		end else begin
			land <= issue;
			if (issue) begin
				rd_addr <= rd_addr + 1'b1;
			end
			case (state)
				eth_frame_loop_pkg::idle: if (ctl_valid) state <= eth_frame_loop_pkg::fetch;
				eth_frame_loop_pkg::fetch: if (ctl_pop) state <= eth_frame_loop_pkg::stream;
				// Wait for the last byte to land
				eth_frame_loop_pkg::stream: if (land && land_last) state <= eth_frame_loop_pkg::idle;
				default: state <= eth_frame_loop_pkg::idle;
			endcase
			if (land) begin
				buf_wr <= ~buf_wr;
			end
			if (pop) begin
				buf_rd <= ~buf_rd;
			end
			buf_cnt <= buf_cnt + 2'(land) - 2'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (state == eth_frame_loop_pkg::idle && ctl_valid) begin
			remaining <= ctl_len;
			off <= '0;
			hit_q <= ctl_hit;
			script_q <= ctl_script;
		end else if (issue) begin
			remaining <= remaining - 1'b1;
			if (off != C_OFF_W'(C_MAX_SCRIPT_SIZE)) begin
				off <= off + 1'b1;
			end
		end
		land_edit <= edit_ok;
		land_last <= remaining == C_LEN_W'(1);
		if (land) begin
			buf_data[buf_wr] <= land_byte;
			buf_last[buf_wr] <= land_last;
		end
	end

endmodule

//--- logic/eth_frame_loop.sv
`timescale 1ns/1ps

module eth_frame_loop #(
	parameter int C_NUM_SCRIPTS = 4,
	parameter int C_MAX_SCRIPT_SIZE = 16,
	parameter int C_LOOP_FIFO_SIZE = 64,
	localparam int C_ADDR_W = $clog2(C_NUM_SCRIPTS * C_MAX_SCRIPT_SIZE)
) (
	input logic clk,
	input logic arst_n,

	input logic [C_NUM_SCRIPTS-1:0] script_en,
	output eth_frame_loop_pkg::count_t overflow_count,

	// Host port
	input logic mem_req,
	input logic [C_ADDR_W-1:0] mem_addr,
	input logic mem_wenable,
	input eth_frame_loop_pkg::script_word_t mem_wdata,
	output eth_frame_loop_pkg::script_word_t mem_rdata,
	output logic mem_ack,

	// Frame input without back-pressure
	input eth_frame_loop_pkg::byte_t s_axis_tdata,
	input logic s_axis_tuser,
	input logic s_axis_tlast,
	input logic s_axis_tvalid,

	output eth_frame_loop_pkg::byte_t m_axis_tdata,
	output logic m_axis_tlast,
	output logic m_axis_tvalid,
	input logic m_axis_tready
);
	localparam int C_IDX_W = C_MAX_SCRIPT_SIZE > 1 ? $clog2(C_MAX_SCRIPT_SIZE) : 1;
	localparam int C_SCRIPT_W = C_NUM_SCRIPTS > 1 ? $clog2(C_NUM_SCRIPTS) : 1;
	localparam int C_PTR_W = $clog2(C_LOOP_FIFO_SIZE);
	localparam int C_LEN_W = C_PTR_W + 1;

	logic [C_IDX_W-1:0] rd_a_addr;
	eth_frame_loop_pkg::script_word_t [C_NUM_SCRIPTS-1:0] rd_a_data;
	logic [C_ADDR_W-1:0] rd_b_addr;
	eth_frame_loop_pkg::script_word_t rd_b_data;

	logic ctl_valid, ctl_pop, ctl_hit;
	logic [C_LEN_W-1:0] ctl_len;
	logic [C_SCRIPT_W-1:0] ctl_script;
	logic [C_PTR_W-1:0] rd_addr;
	eth_frame_loop_pkg::byte_t rd_data;

	eth_frame_loop_if #(.C_NUM_SCRIPTS(C_NUM_SCRIPTS), .C_MAX_SCRIPT_SIZE(C_MAX_SCRIPT_SIZE)) rx2cmp ();
	eth_frame_loop_if #(.C_NUM_SCRIPTS(C_NUM_SCRIPTS), .C_MAX_SCRIPT_SIZE(C_MAX_SCRIPT_SIZE)) cmp2fifo ();

	eth_frame_loop_script_ram #(
		.C_NUM_SCRIPTS(C_NUM_SCRIPTS),
		.C_MAX_SCRIPT_SIZE(C_MAX_SCRIPT_SIZE)
	) i_script_ram (
		.clk(clk), .arst_n(arst_n),
		.mem_req(mem_req), .mem_addr(mem_addr), .mem_wenable(mem_wenable),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack),
		.rd_a_addr(rd_a_addr), .rd_a_data(rd_a_data),
		.rd_b_addr(rd_b_addr), .rd_b_data(rd_b_data)
	);

	eth_frame_loop_rx #(.C_MAX_SCRIPT_SIZE(C_MAX_SCRIPT_SIZE)) i_rx (
		.clk(clk), .arst_n(arst_n),
		.s_axis_tdata(s_axis_tdata), .s_axis_tuser(s_axis_tuser),
		.s_axis_tlast(s_axis_tlast), .s_axis_tvalid(s_axis_tvalid),
		.rd_a_addr(rd_a_addr), .cmp(rx2cmp.src)
	);

	eth_frame_loop_compare #(
		.C_NUM_SCRIPTS(C_NUM_SCRIPTS),
		.C_MAX_SCRIPT_SIZE(C_MAX_SCRIPT_SIZE)
	) i_compare (
		.clk(clk), .arst_n(arst_n),
		.script_en(script_en), .rd_a_data(rd_a_data),
		.s(rx2cmp.dst), .m(cmp2fifo.src)
	);

	eth_frame_loop_fifo #(
		.C_NUM_SCRIPTS(C_NUM_SCRIPTS),
		.C_LOOP_FIFO_SIZE(C_LOOP_FIFO_SIZE)
	) i_fifo (
		.clk(clk), .arst_n(arst_n), .s(cmp2fifo.dst),
		.ctl_valid(ctl_valid), .ctl_len(ctl_len), .ctl_hit(ctl_hit),
		.ctl_script(ctl_script), .ctl_pop(ctl_pop),
		.rd_addr(rd_addr), .rd_data(rd_data), .overflow_count(overflow_count)
	);

	eth_frame_loop_tx #(
		.C_NUM_SCRIPTS(C_NUM_SCRIPTS),
		.C_MAX_SCRIPT_SIZE(C_MAX_SCRIPT_SIZE),
		.C_LOOP_FIFO_SIZE(C_LOOP_FIFO_SIZE)
	) i_tx (
		.clk(clk), .arst_n(arst_n),
		.ctl_valid(ctl_valid), .ctl_len(ctl_len), .ctl_hit(ctl_hit),
		.ctl_script(ctl_script), .ctl_pop(ctl_pop),
		.rd_addr(rd_addr), .rd_data(rd_data),
		.rd_b_addr(rd_b_addr), .rd_b_data(rd_b_data),
		.m_axis_tdata(m_axis_tdata), .m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready)
	);

endmodule

//--- tb/eth_frame_loop_tb.sv
`timescale 1ns/1ps

module eth_frame_loop_tb;

	localparam int C_NUM_SCRIPTS = 4;
	localparam int C_MAX_SCRIPT_SIZE = 16;
	localparam int C_LOOP_FIFO_SIZE = 64;
	localparam int C_ADDR_W = $clog2(C_NUM_SCRIPTS * C_MAX_SCRIPT_SIZE);
	localparam int C_DRAIN_TIMEOUT = 5000;
	localparam int C_COUNT_TIMEOUT = 20;

	logic clk;
	logic arst_n;
	logic [C_NUM_SCRIPTS-1:0] script_en;
	eth_frame_loop_pkg::count_t overflow_count;
	logic mem_req;
	logic [C_ADDR_W-1:0] mem_addr;
	logic mem_wenable;
	eth_frame_loop_pkg::script_word_t mem_wdata;
	eth_frame_loop_pkg::script_word_t mem_rdata;
	logic mem_ack;
	eth_frame_loop_pkg::byte_t s_axis_tdata;
	logic s_axis_tuser;
	logic s_axis_tlast;
	logic s_axis_tvalid;
	eth_frame_loop_pkg::byte_t m_axis_tdata;
	logic m_axis_tlast;
	logic m_axis_tvalid;
	logic m_axis_tready = 1'b1;

	// Expected output beats in output order
	eth_frame_loop_pkg::byte_t exp_data [$];
	logic exp_last [$];

	// 0 always ready, 1 random, 2 held low
	int stall_mode = 0;
	int seed = 32'h61e8_1591;
	int rnd;
	logic held = 1'b0;
	eth_frame_loop_pkg::byte_t held_data;
	logic held_last;

	eth_frame_loop #(
		.C_NUM_SCRIPTS(C_NUM_SCRIPTS),
		.C_MAX_SCRIPT_SIZE(C_MAX_SCRIPT_SIZE),
		.C_LOOP_FIFO_SIZE(C_LOOP_FIFO_SIZE)
	) i_eth_frame_loop (
		.clk(clk),
		.arst_n(arst_n),
		.script_en(script_en),
		.overflow_count(overflow_count),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_wenable(mem_wenable),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.mem_ack(mem_ack),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tuser(s_axis_tuser),
		.s_axis_tlast(s_axis_tlast),
		.s_axis_tvalid(s_axis_tvalid),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready)
	);

	always #5 clk = ~clk;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected) else
			stop_run($sformatf("mismatch at %0t: %s got %0h expected %0h",
				$time, name, got, expected));
	endtask

	task automatic read_hex(input int fd, output int value);
		int code;
		code = $fscanf(fd, " %h", value);
		assert (code == 1) else
			stop_run("test data ends in the middle of a command");
	endtask

	// Ack is due exactly one cycle after the request
	task automatic host_access(input logic is_write, input logic [C_ADDR_W-1:0] addr,
			input eth_frame_loop_pkg::script_word_t data);
		@(negedge clk);
		check_value("mem_ack", mem_ack, 1'b0);
		mem_req = 1'b1;
		mem_addr = addr;
		mem_wenable = is_write;
		mem_wdata = is_write ? data : '0;
		@(negedge clk);
		mem_req = 1'b0;
		mem_wenable = 1'b0;
		check_value("mem_ack", mem_ack, 1'b1);
		if (!is_write) begin
			check_value("mem_rdata", mem_rdata, data);
		end
	endtask

	task automatic wait_drained(input int drops);
		int cycles;
		cycles = 0;
		while (exp_data.size() != 0 && cycles < C_DRAIN_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		assert (exp_data.size() == 0) else
			stop_run($sformatf("timeout at %0t with %0d expected output bytes missing",
				$time, exp_data.size()));
		cycles = 0;
		while (overflow_count != 32'(drops) && cycles < C_COUNT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		check_value("overflow_count", overflow_count, drops);
	endtask

	// Tready changes only on the falling edge
	always @(negedge clk) begin
		if (held) begin
			check_value("m_axis_tvalid", m_axis_tvalid, 1'b1);
			check_value("m_axis_tdata", m_axis_tdata, held_data);
			check_value("m_axis_tlast", m_axis_tlast, held_last);
		end
		case (stall_mode)
			0: m_axis_tready = 1'b1;
			1: begin
				rnd = $random(seed);
				m_axis_tready = rnd[0];
			end
			default: m_axis_tready = 1'b0;
		endcase
		held = m_axis_tvalid && !m_axis_tready;
		held_data = m_axis_tdata;
		held_last = m_axis_tlast;
		if (m_axis_tvalid && m_axis_tready) begin
			assert (exp_data.size() != 0) else
				stop_run($sformatf("unexpected output byte %02h at %0t", m_axis_tdata, $time));
			check_value("m_axis_tdata", m_axis_tdata, exp_data.pop_front());
			check_value("m_axis_tlast", m_axis_tlast, exp_last.pop_front());
		end
	end

	initial begin
		int fd;
		int c;
		int a;
		int b;
		int n;
		int bad;
		byte cmd;
		clk = 1'b0;
		arst_n = 1'b0;
		script_en = '0;
		mem_req = 1'b0;
		mem_addr = '0;
		mem_wenable = 1'b0;
		mem_wdata = '0;
		s_axis_tdata = '0;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		fd = $fopen("tb/eth_frame_loop_testdata.txt", "r");
		assert (fd != 0) else
			stop_run("cannot open tb/eth_frame_loop_testdata.txt");
		while ($fscanf(fd, " %c", cmd) == 1) begin
			case (cmd)
				"#": begin
					c = $fgetc(fd);
					while (c != 10 && c != -1) begin
						c = $fgetc(fd);
					end
				end
				"W", "R": begin
					read_hex(fd, a);
					read_hex(fd, b);
					host_access(cmd == "W", C_ADDR_W'(a), b);
				end
				"E": begin
					read_hex(fd, a);
					// Last beat of the previous frame must clear the execute stage
					repeat (2) @(negedge clk);
					script_en = C_NUM_SCRIPTS'(a);
				end
				"S": begin
					read_hex(fd, a);
					@(posedge clk);
					stall_mode = a;
				end
				"I": begin
					read_hex(fd, bad);
					read_hex(fd, n);
					for (int i = 0; i < n; i++) begin
						read_hex(fd, a);
						@(negedge clk);
						s_axis_tvalid = 1'b1;
						s_axis_tdata = 8'(a);
						s_axis_tuser = bad[0];
						s_axis_tlast = i == n - 1;
					end
					@(negedge clk);
					s_axis_tvalid = 1'b0;
					s_axis_tuser = 1'b0;
					s_axis_tlast = 1'b0;
				end
				"O": begin
					read_hex(fd, n);
					for (int i = 0; i < n; i++) begin
						read_hex(fd, a);
						exp_data.push_back(8'(a));
						exp_last.push_back(i == n - 1);
					end
				end
				"D": begin
					read_hex(fd, a);
					wait_drained(a);
				end
				default: stop_run($sformatf("unknown command %c in the test data", cmd));
			endcase
		end
		$fclose(fd);

		if (exp_data.size() == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			stop_run($sformatf("%0d expected output bytes never checked", exp_data.size()));
		end
	end

endmodule

//--- tb/eth_frame_loop_testdata.txt
# One command per line, every number in hex
# W/R addr word, E enable mask, S tready mode (0 ready 1 random 2 low), D total drops
# I bad len bytes (input frame), O len bytes (expected output frame)
S 0
E F
I 0 11 00 11 22 33 44 55 66 77 88 99 AA BB CC DD EE FF 10
O 11 00 11 22 33 44 55 66 77 88 99 AA BB CC DD EE FF 10
D 0
W 00 FF11FF99
W 11 F020FFEE
W 20 FFAA0F05
W 2F 0000FF77
W 32 0000FF33
W 35 FF550000
R 20 FFAA0F05
R 35 FF550000
E 4
I 0 12 AA 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 11
O 12 A5 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 77 10 11
E F
I 0 6 11 25 C0 C1 C2 55
O 6 99 25 C0 C1 C2 55
E E
I 0 6 11 25 C0 C1 C2 55
O 6 11 EE C0 C1 C2 55
E 8
I 0 6 11 25 C0 C1 C2 55
O 6 11 25 33 C1 C2 55
I 0 6 11 25 C0 C1 C2 54
O 6 11 25 C0 C1 C2 54
I 0 3 11 25 C0
O 3 11 25 33
E 3
I 0 3 AA 30 40
O 3 AA 30 40
I 1 4 DE AD BE EF
D 1
E 0
S 2
I 0 1E 00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D
O 1E 00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D
I 0 1E 20 21 22 23 24 25 26 27 28 29 2A 2B 2C 2D 2E 2F 30 31 32 33 34 35 36 37 38 39 3A 3B 3C 3D
O 1E 20 21 22 23 24 25 26 27 28 29 2A 2B 2C 2D 2E 2F 30 31 32 33 34 35 36 37 38 39 3A 3B 3C 3D
I 0 14 40 41 42 43 44 45 46 47 48 49 4A 4B 4C 4D 4E 4F 50 51 52 53
I 0 4 80 81 82 83
O 4 80 81 82 83
I 0 2 90 91
S 0
D 3
S 1
E 4
I 0 12 AA 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 11
O 12 A5 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 77 10 11
E F
I 0 6 11 25 C0 C1 C2 55
O 6 99 25 C0 C1 C2 55
I 0 1E 00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D
O 1E 00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 11 12 13 14 15 16 17 18 19 1A 1B 1C 1D
D 3

//--- eth_frame_loop.f
logic/eth_frame_loop_pkg.sv
logic/eth_frame_loop_if.sv
logic/eth_frame_loop_script_ram.sv
logic/eth_frame_loop_rx.sv
logic/eth_frame_loop_compare.sv
logic/eth_frame_loop_fifo.sv
logic/eth_frame_loop_tx.sv
logic/eth_frame_loop.sv
tb/eth_frame_loop_tb.sv

//--- Makefile
TOP = eth_frame_loop_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f eth_frame_loop.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f eth_frame_loop.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
